// ==== dv/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== dv/tb_exu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exu_core;

	localparam logic [6:0] op_reg = 7'h33;
	localparam logic [6:0] op_imm = 7'h13;
	localparam logic [6:0] op_lui = 7'h37;
	localparam int max_entries = 512;

	logic clk;
	logic rst_n;
	logic instr_valid;
	logic [31:0] instr;
	logic wb_valid;
	logic [4:0] wb_rd;
	logic [63:0] wb_data;

	logic tbl_valid [0:max_entries-1];
	logic [31:0] tbl_instr [0:max_entries-1];
	logic exp_valid [0:max_entries-1];
	logic [4:0] exp_rd [0:max_entries-1];
	logic [63:0] exp_data [0:max_entries-1];
	logic [63:0] shadow [0:31]; // reference register file
	logic [4:0] pool [0:7];
	int n_entries;
	int errors;
	int checks;
	int cycle_cnt = 0;
	int cycle_limit = max_entries;
	integer seed;

	clk_gen u_clk_gen (
		.clk(clk),
		.rst_n(rst_n)
	);

	exu_core u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

	function automatic logic [31:0] r_type(input logic [2:0] f3, input logic alt,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op_imm};
	endfunction

	function automatic logic [31:0] shift_imm(input logic [2:0] f3, input logic arith,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [5:0] sh);
		return {1'b0, arith, 4'b0, sh, rs1, f3, rd, op_imm};
	endfunction

	function automatic logic [31:0] lui_instr(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, op_lui};
	endfunction

	// one table entry, executed on the shadow registers
	task automatic model_step(input logic v, input logic [31:0] ins);
		logic [6:0] opc;
		logic [4:0] rd;
		logic [2:0] f3;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] res;
		logic ok;
		opc = ins[6:0];
		rd = ins[11:7];
		f3 = ins[14:12];
		a = shadow[ins[19:15]];
		b = (opc == op_reg) ? shadow[ins[24:20]] : {{52{ins[31]}}, ins[31:20]};
		case (f3)
			3'd0: res = (opc == op_reg && ins[30]) ? a - b : a + b;
			3'd1: res = a << b[5:0];
			3'd2: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			3'd3: res = (a < b) ? 64'd1 : 64'd0;
			3'd4: res = a ^ b;
			3'd5: begin
				if (ins[30]) begin
					res = $signed(a) >>> b[5:0];
				end else begin
					res = a >> b[5:0];
				end
			end
			3'd6: res = a | b;
			default: res = a & b;
		endcase
		ok = (opc == op_reg) || (opc == op_imm) || (opc == op_lui);
		if (opc == op_lui) begin
			res = {{32{ins[31]}}, ins[31:12], 12'h000};
		end
		ok = ok && v && (rd != 5'd0);
		tbl_valid[n_entries] = v;
		tbl_instr[n_entries] = ins;
		exp_valid[n_entries] = ok;
		exp_rd[n_entries] = rd;
		exp_data[n_entries] = res;
		if (ok) begin
			shadow[rd] = res;
		end
		n_entries++;
	endtask

	// lui, addi and slli chain, about 64 random bits
	task automatic load_random(input logic [4:0] rd);
		logic [31:0] r;
		r = $random(seed);
		model_step(1'b1, lui_instr(rd, r[19:0]));
		model_step(1'b1, i_type(3'd0, rd, rd, r[31:20]));
		r = $random(seed);
		model_step(1'b1, shift_imm(3'd1, 1'b0, rd, rd, 6'd20));
		model_step(1'b1, i_type(3'd0, rd, rd, r[11:0]));
		model_step(1'b1, shift_imm(3'd1, 1'b0, rd, rd, 6'd12));
		model_step(1'b1, i_type(3'd0, rd, rd, r[23:12]));
	endtask

	task automatic build_table();
		logic [31:0] r;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic [2:0] f3;
		model_step(1'b1, r_type(3'd0, 1'b0, 5'd1, 5'd2, 5'd3)); // fresh regs read zero
		model_step(1'b1, r_type(3'd0, 1'b0, 5'd4, 5'd1, 5'd0));
		for (int k = 1; k <= 4; k++) begin
			load_random(5'(k));
		end
		for (int k = 0; k < 8; k++) begin
			r = $random(seed);
			model_step(1'b1, r_type(3'd0, 1'b0, 5'd5, pool[r[2:0]], pool[r[5:3]]));
			model_step(1'b1, r_type(3'd0, 1'b1, 5'd6, pool[r[2:0]], pool[r[5:3]]));
			model_step(1'b1, i_type(3'd0, 5'd7, pool[r[8:6]], r[20:9]));
			model_step(1'b1, lui_instr(5'd8, r[31:12]));
		end
		model_step(1'b1, i_type(3'd0, 5'd11, 5'd0, 12'hfff));
		model_step(1'b1, shift_imm(3'd5, 1'b0, 5'd11, 5'd11, 6'd1)); // max positive
		model_step(1'b1, i_type(3'd0, 5'd12, 5'd11, 12'h001)); // wraps to min negative
		model_step(1'b1, r_type(3'd0, 1'b0, 5'd13, 5'd11, 5'd11));
		model_step(1'b1, r_type(3'd0, 1'b1, 5'd14, 5'd12, 5'd11));
		model_step(1'b1, r_type(3'd2, 1'b0, 5'd15, 5'd12, 5'd11));
		model_step(1'b1, r_type(3'd3, 1'b0, 5'd15, 5'd12, 5'd11));
		model_step(1'b1, i_type(3'd2, 5'd17, 5'd12, 12'h000));
		model_step(1'b1, i_type(3'd3, 5'd17, 5'd11, 12'hfff));
		load_random(5'd18);
		model_step(1'b1, r_type(3'd4, 1'b0, 5'd19, 5'd18, 5'd12)); // only sign bit differs
		for (int k = 0; k < 4; k++) begin
			rs1 = k[0] ? 5'd19 : 5'd18;
			rs2 = k[0] ? 5'd18 : 5'd19;
			model_step(1'b1, r_type(k[1] ? 3'd3 : 3'd2, 1'b0, 5'd20, rs1, rs2));
		end
		model_step(1'b1, i_type(3'd7, 5'd20, 5'd1, 12'hf0f));
		model_step(1'b1, i_type(3'd6, 5'd20, 5'd2, 12'h8a5));
		model_step(1'b1, i_type(3'd4, 5'd20, 5'd3, 12'hfff));
		for (int k = 0; k < 32; k++) begin
			r = $random(seed);
			rs1 = pool[r[2:0]];
			rs2 = pool[r[5:3]];
			f3 = r[8:6];
			rd = 5'd28 + r[12:11];
			if (r[31:29] == 3'd0) begin
				model_step(1'b0, r);
			end else if (r[9]) begin
				model_step(1'b1, r_type(f3, r[10] && (f3 == 3'd0 || f3 == 3'd5), rd, rs1, rs2));
			end else if (f3 == 3'd1 || f3 == 3'd5) begin
				model_step(1'b1, shift_imm(f3, r[10] && f3 == 3'd5, rd, rs1, r[18:13]));
			end else begin
				model_step(1'b1, i_type(f3, rd, rs1, r[24:13]));
			end
		end
		for (int sh = 0; sh < 64; sh++) begin
			f3 = (sh % 3 == 0) ? 3'd1 : 3'd5;
			model_step(1'b1, shift_imm(f3, sh % 3 == 2, 5'd22, pool[sh % 8], 6'(sh)));
		end
		for (int k = 0; k < 12; k++) begin
			r = $random(seed);
			f3 = (k % 3 == 0) ? 3'd1 : 3'd5;
			model_step(1'b1, r_type(f3, k % 3 == 2, 5'd21, pool[r[2:0]], pool[r[5:3]]));
		end
		model_step(1'b1, i_type(3'd0, 5'd23, 5'd1, 12'h005));
		model_step(1'b1, r_type(3'd0, 1'b0, 5'd24, 5'd23, 5'd23)); // distance one
		model_step(1'b1, i_type(3'd0, 5'd25, 5'd0, 12'h001));
		model_step(1'b1, r_type(3'd0, 1'b1, 5'd26, 5'd24, 5'd23)); // distance two and three
		model_step(1'b1, r_type(3'd0, 1'b0, 5'd23, 5'd26, 5'd26));
		model_step(1'b1, r_type(3'd4, 1'b0, 5'd26, 5'd23, 5'd24));
		model_step(1'b0, i_type(3'd0, 5'd23, 5'd0, 12'd77)); // dropped, no forward
		model_step(1'b1, r_type(3'd0, 1'b0, 5'd0, 5'd1, 5'd2));
		model_step(1'b1, {12'h123, 5'd1, 3'd0, 5'd24, 7'b0000011}); // load opcode
		model_step(1'b1, r_type(3'd0, 1'b0, 5'd27, 5'd23, 5'd24));
		model_step(1'b1, r_type(3'd0, 1'b0, 5'd27, 5'd0, 5'd27));
	endtask

	task automatic check_output(input int j);
		checks++;
		assert (wb_valid === exp_valid[j]) else begin
			errors++;
			$display("Error: wb_valid = %h, expected %h (entry %0d)", wb_valid, exp_valid[j], j);
		end
		if (exp_valid[j]) begin
			assert (wb_rd === exp_rd[j]) else begin
				errors++;
				$display("Error: wb_rd = %h, expected %h (entry %0d)", wb_rd, exp_rd[j], j);
			end
			assert (wb_data === exp_data[j]) else begin
				errors++;
				$display("Error: wb_data = %h, expected %h (entry %0d)", wb_data, exp_data[j], j);
			end
		end
	endtask

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("run timed out after %0d cycles without finishing the table", cycle_cnt);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		instr_valid = 1'b0;
		instr = 32'h0;
		errors = 0;
		checks = 0;
		n_entries = 0;
		seed = 32'h3afa62d9;
		pool = '{5'd1, 5'd2, 5'd3, 5'd4, 5'd11, 5'd12, 5'd18, 5'd19};
		for (int i = 0; i < 32; i++) begin
			shadow[i] = 64'h0;
		end
		build_table();
		cycle_limit = n_entries + 8 + 16;
		@(posedge clk);
		repeat (7) begin
			@(negedge clk);
			checks++;
			assert (wb_valid === 1'b0 && wb_data === 64'h0) else begin
				errors++;
				$display("Error: wb_valid = %h wb_data = %h in reset, expected 0", wb_valid,
					wb_data);
			end
		end
		wait (rst_n === 1'b1);
		for (int c = 0; c < n_entries + 3; c++) begin
			@(posedge clk);
			instr_valid <= (c < n_entries) ? tbl_valid[c] : 1'b0;
			instr <= (c < n_entries) ? tbl_instr[c] : 32'h0;
			@(negedge clk);
			if (c >= 3) begin
				check_output(c - 3);
			end else begin
				checks++;
				assert (wb_valid === 1'b0) else begin
					errors++;
					$display("Error: wb_valid = %h before first result, expected 0", wb_valid);
				end
			end
		end
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/alu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_execute import exu_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire exec_req_t dec_q,
	output wb_req_t ex_next,
	output wb_req_t ex_q
);

	logic [xlen-1:0] op_a;
	logic [xlen-1:0] op_b;
	logic [xlen-1:0] b_sel;
	logic sub_en;
	logic [xlen-1:0] sum;
	logic carry;
	logic overflow;
	logic lt_s;
	logic lt_u;
	logic [xlen-1:0] shift_out;
	logic [xlen-1:0] result;

	assign op_a = dec_q.op_a;
	assign op_b = dec_q.op_b;
	assign sub_en = dec_q.alu_ctl[3];

	// one adder for add, sub and both compares
	assign b_sel = op_b ^ {xlen{sub_en}};
	assign {carry, sum} = {1'b0, op_a} + {1'b0, b_sel} + {{xlen{1'b0}}, sub_en};
	assign overflow = (op_a[xlen-1] == b_sel[xlen-1]) && (sum[xlen-1] != op_a[xlen-1]);

	assign lt_s = sum[xlen-1] ^ overflow;
	assign lt_u = ~carry; // borrow out

	barrel_shifter u_shifter (
		.data(op_a),
		.shamt(op_b[5:0]),
		.shift_right(dec_q.alu_ctl[2]),
		.arith(dec_q.alu_ctl[3]),
		.result(shift_out)
	);

	always_comb begin
		case (dec_q.alu_ctl[2:0])
			3'b000: result = sum;
			3'b001: result = shift_out;
			3'b010: result = {{(xlen-1){1'b0}}, lt_s};
			3'b011: result = {{(xlen-1){1'b0}}, lt_u};
			3'b100: result = op_a ^ op_b;
			3'b101: result = shift_out;
			3'b110: result = op_a | op_b;
			default: result = op_a & op_b;
		endcase
	end

	always_comb begin
		ex_next.valid = dec_q.valid;
		ex_next.rd = dec_q.rd;
		ex_next.data = result;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_q <= '0;
		end else begin
			ex_q <= ex_next;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/barrel_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module barrel_shifter import exu_pkg::*; (
	input wire logic [xlen-1:0] data,
	input wire logic [5:0] shamt,
	input wire logic shift_right,
	input wire logic arith,
	output logic [xlen-1:0] result
);

	logic [xlen-1:0] rev_in;
	logic [xlen-1:0] stage [0:6];
	logic fill;

	// left shifts run through the right shifter on reversed data
	always_comb begin
		for (int i = 0; i < xlen; i++) begin
			rev_in[i] = data[xlen-1-i];
		end
	end

	assign fill = shift_right && arith && data[xlen-1];

	always_comb begin
		stage[0] = shift_right ? data : rev_in;
		for (int s = 0; s < 6; s++) begin
			if (shamt[s]) begin
				stage[s+1] = (stage[s] >> (1 << s)) | ({xlen{fill}} << (xlen - (1 << s)));
			end else begin
				stage[s+1] = stage[s];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < xlen; i++) begin
			result[i] = shift_right ? stage[6][i] : stage[6][xlen-1-i];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/exu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_core import exu_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic instr_valid,
	input wire logic [31:0] instr,
	output logic wb_valid,
	output logic [reg_addr_w-1:0] wb_rd,
	output logic [xlen-1:0] wb_data
);

	logic [reg_addr_w-1:0] rs1_addr;
	logic [reg_addr_w-1:0] rs2_addr;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	exec_req_t dec_q;
	wb_req_t ex_next;
	wb_req_t ex_q;
	wb_req_t wb;

	instr_decode u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.ex_next(ex_next),
		.ex_q(ex_q),
		.dec_q(dec_q)
	);

	alu_execute u_execute (
		.clk(clk),
		.rst_n(rst_n),
		.dec_q(dec_q),
		.ex_next(ex_next),
		.ex_q(ex_q)
	);

	result_writeback u_writeback (
		.clk(clk),
		.rst_n(rst_n),
		.ex_q(ex_q),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.wb(wb)
	);

	assign wb_valid = wb.valid;
	assign wb_rd = wb.rd;
	assign wb_data = wb.data;

endmodule

`default_nettype wire

// ==== hdl/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

	localparam int xlen = 64;
	localparam int reg_addr_w = 5;

	// major opcodes
	localparam logic [6:0] opc_op = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui = 7'b0110111;

	localparam logic [2:0] f3_add = 3'b000;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_sr = 3'b101;

	// bit 3 inverts b with carry in, low bits pick the result
	typedef enum logic [3:0] {
		alu_add = 4'b0000,
		alu_sll = 4'b0001,
		alu_xor = 4'b0100,
		alu_srl = 4'b0101,
		alu_or = 4'b0110,
		alu_and = 4'b0111,
		alu_sub = 4'b1000,
		alu_slt = 4'b1010,
		alu_sltu = 4'b1011,
		alu_sra = 4'b1101
	} alu_ctl_t;

	typedef struct packed {
		logic valid;
		logic [reg_addr_w-1:0] rd;
		alu_ctl_t alu_ctl;
		logic [xlen-1:0] op_a;
		logic [xlen-1:0] op_b;
	} exec_req_t;

	typedef struct packed {
		logic valid;
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0] data;
	} wb_req_t;

endpackage

`default_nettype wire

// ==== hdl/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode import exu_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic instr_valid,
	input wire logic [31:0] instr,
	output logic [reg_addr_w-1:0] rs1_addr,
	output logic [reg_addr_w-1:0] rs2_addr,
	input wire logic [xlen-1:0] rs1_data,
	input wire logic [xlen-1:0] rs2_data,
	input wire wb_req_t ex_next,
	input wire wb_req_t ex_q,
	output exec_req_t dec_q
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic f7_b5;
	logic [reg_addr_w-1:0] rd;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] src1;
	logic [xlen-1:0] src2;
	logic is_cmp;
	logic is_sr;
	logic supported;
	exec_req_t dec_d;

	// newest producer wins, x0 never forwarded
	function automatic logic [xlen-1:0] fwd(
		input logic [reg_addr_w-1:0] addr,
		input logic [xlen-1:0] rf_data,
		input wb_req_t nxt,
		input wb_req_t cur
	);
		logic [xlen-1:0] val;
		val = rf_data;
		if (addr != '0) begin
			if (nxt.valid && nxt.rd == addr) begin
				val = nxt.data;
			end else if (cur.valid && cur.rd == addr) begin
				val = cur.data;
			end
		end
		return val;
	endfunction

	assign opcode = instr[6:0];
	assign rd = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1_addr = instr[19:15];
	assign rs2_addr = instr[24:20];
	assign f7_b5 = instr[30];

	assign imm_i = {{(xlen-12){instr[31]}}, instr[31:20]};
	assign imm_u = {{(xlen-32){instr[31]}}, instr[31:12], 12'b0};

	assign src1 = fwd(rs1_addr, rs1_data, ex_next, ex_q);
	assign src2 = fwd(rs2_addr, rs2_data, ex_next, ex_q);

	assign is_cmp = (funct3 == f3_slt) || (funct3 == f3_sltu); // compares need subtract
	assign is_sr = (funct3 == f3_sr);
	assign supported = (opcode == opc_op) || (opcode == opc_op_imm) || (opcode == opc_lui);

	always_comb begin
		dec_d.valid = instr_valid && supported && (rd != '0); // x0 writes dropped here
		dec_d.rd = rd;
		dec_d.op_a = src1;
		dec_d.op_b = src2;
		dec_d.alu_ctl = alu_add;
		case (opcode)
			opc_op: begin
				dec_d.alu_ctl = alu_ctl_t'({(f7_b5 && (funct3 == f3_add || is_sr)) || is_cmp,
					funct3});
			end
			opc_op_imm: begin
				dec_d.op_b = imm_i;
				dec_d.alu_ctl = alu_ctl_t'({(f7_b5 && is_sr) || is_cmp, funct3}); // no subi
			end
			opc_lui: begin
				dec_d.op_a = '0;
				dec_d.op_b = imm_u;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec_q <= '0;
		end else begin
			dec_q <= dec_d;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/result_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_writeback import exu_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire wb_req_t ex_q,
	input wire logic [reg_addr_w-1:0] rs1_addr,
	input wire logic [reg_addr_w-1:0] rs2_addr,
	output logic [xlen-1:0] rs1_data,
	output logic [xlen-1:0] rs2_data,
	output wb_req_t wb
);

	logic [xlen-1:0] regs [1:31]; // x0 has no storage

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (ex_q.valid && ex_q.rd != '0) begin
			regs[ex_q.rd] <= ex_q.data;
		end
	end

	// async read ports
	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb <= '0;
		end else begin
			wb <= ex_q;
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/exu_pkg.sv
hdl/barrel_shifter.sv
hdl/instr_decode.sv
hdl/alu_execute.sv
hdl/result_writeback.sv
hdl/exu_core.sv
dv/clk_gen.sv
dv/tb_exu_core.sv
